// File: logic/player_pkg.sv
package player_pkg;

  // ========================================
  // Widths that carry a meaning
  // ========================================

  // Word address into the flash
  typedef logic [22:0] flash_addr_t;

  // One 32-bit flash word holds two samples
  typedef logic [31:0] flash_word_t;

  typedef logic [15:0] sample_t;

  // Signed offset applied to the scope count
  typedef logic signed [15:0] speed_t;

  typedef logic [15:0] clock_count_t;

  // Active low, bit 0 is segment a, bit 6 is segment g
  typedef logic [6:0] seg_t;

  // ========================================
  // Constants
  // ========================================

  localparam int hex_digits = 6;
  localparam speed_t speed_step = 16'sd100;
  localparam clock_count_t default_clock_count = 16'd12499;
  // Millisecond ticks between two events of one button
  localparam int event_window_ticks = 100;

  // ========================================
  // Bundles
  // ========================================

  // Flash read port, reader side
  typedef struct packed {
    logic        read;
    flash_addr_t address;
  } flash_req_t;

  // Flash read port, controller side
  typedef struct packed {
    flash_word_t readdata;
    logic        readdatavalid;
  } flash_rsp_t;

  // Element 0 is the least significant digit
  typedef seg_t [hex_digits-1:0] hex_bus_t;

  // Push buttons, all active low
  typedef struct packed {
    logic speed_up;
    logic speed_down;
    logic speed_reset;
  } key_t;

endpackage

// File: logic/rate_tick_gen.sv
`timescale 1ns/1ns

module rate_tick_gen #(
  parameter int DIVIDE = 2
) (
  input  logic CLK_50M,
  input  logic rst_n,
  output logic tick
);

  localparam int cnt_w = (DIVIDE > 1) ? $clog2(DIVIDE) : 1;

  logic [cnt_w-1:0] count;

  // Down counter, one tick per DIVIDE cycles
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      count <= cnt_w'(DIVIDE - 1);
      tick  <= 1'b0;
    end
    else if (count == '0)
    begin
      count <= cnt_w'(DIVIDE - 1);
      tick  <= 1'b1;
    end
    else
    begin
      count <= count - 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

// File: logic/flash_sample_reader.sv
`timescale 1ns/1ns

module flash_sample_reader (
  input  logic                   CLK_50M,
  input  logic                   rst_n,
  input  logic                   sample_tick,
  input  player_pkg::flash_rsp_t flash_rsp,
  output player_pkg::flash_req_t flash_req,
  output player_pkg::sample_t    sample,
  output logic                   sample_strobe
);

  import player_pkg::*;

  typedef enum logic {
    idle,
    wait_data
  } reader_state_t;

  reader_state_t state;
  logic          read;
  flash_addr_t   address;

  assign flash_req.read    = read;
  assign flash_req.address = address;

  // ========================================
  // Read FSM and address counter
  // ========================================

  // Ticks seen while a read is pending are dropped
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      state         <= idle;
      read          <= 1'b0;
      address       <= '0;
      sample_strobe <= 1'b0;
    end
    else
    begin
      sample_strobe <= 1'b0;
      case (state)
        idle:
        begin
          if (sample_tick)
          begin
            read  <= 1'b1;
            state <= wait_data;
          end
        end
        wait_data:
        begin
          // Address holds until the data arrives
          if (flash_rsp.readdatavalid)
          begin
            read          <= 1'b0;
            address       <= address + 1'b1;
            sample_strobe <= 1'b1;
            state         <= idle;
          end
        end
        default:
        begin
          read  <= 1'b0;
          state <= idle;
        end
      endcase
    end
  end

  // Odd addresses take the upper half of the word
  always_ff @(posedge CLK_50M)
  begin
    if (state == wait_data && flash_rsp.readdatavalid)
      sample <= address[0] ? flash_rsp.readdata[31:16] : flash_rsp.readdata[15:0];
  end

endmodule

// File: logic/button_event_gen.sv
`timescale 1ns/1ns

module button_event_gen (
  input  logic             CLK_50M,
  input  logic             rst_n,
  input  logic             ms_tick,
  input  player_pkg::key_t key,
  output logic             up_event,
  output logic             down_event,
  output logic             reset_event
);

  import player_pkg::*;

  localparam int win_w = $clog2(event_window_ticks);

  key_t             key_meta;
  key_t             key_sync;
  logic [win_w-1:0] win_count;
  logic             window_end;
  logic             up_held;
  logic             down_held;

  // Two-flop synchronizer, idle level is released
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      key_meta <= '1;
      key_sync <= '1;
    end
    else
    begin
      key_meta <= key;
      key_sync <= key_meta;
    end
  end

  // Buttons become active high here
  assign up_held     = ~key_sync.speed_up;
  assign down_held   = ~key_sync.speed_down;
  assign reset_event = ~key_sync.speed_reset;

  assign window_end = ms_tick && (win_count == win_w'(event_window_ticks - 1));

  // ========================================
  // Rate limiting window
  // ========================================

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      win_count  <= '0;
      up_event   <= 1'b0;
      down_event <= 1'b0;
    end
    else
    begin
      if (window_end)
        win_count <= '0;
      else if (ms_tick)
        win_count <= win_count + 1'b1;
      // One pulse per window while held
      up_event   <= window_end && up_held;
      down_event <= window_end && down_held;
    end
  end

endmodule

// File: logic/speed_control.sv
`timescale 1ns/1ns

module speed_control (
  input  logic                     CLK_50M,
  input  logic                     rst_n,
  input  logic                     up_event,
  input  logic                     down_event,
  input  logic                     reset_event,
  output player_pkg::clock_count_t clock_count
);

  import player_pkg::*;

  speed_t offset;

  // Reset key wins, up and down together cancel
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      offset <= '0;
    else if (reset_event)
      offset <= '0;
    else if (up_event && !down_event)
      offset <= offset + speed_step;
    else if (down_event && !up_event)
      offset <= offset - speed_step;
  end

  // Scope count trails the offset by one cycle
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      clock_count <= default_clock_count;
    else
      clock_count <= default_clock_count + clock_count_t'(offset);
  end

endmodule

// File: logic/hex_display.sv
`timescale 1ns/1ns

module hex_display (
  input  logic                     CLK_50M,
  input  logic                     rst_n,
  input  logic                     display_tick,
  input  player_pkg::clock_count_t clock_count,
  output player_pkg::hex_bus_t     hex
);

  import player_pkg::*;

  localparam int value_w = 4 * hex_digits;

  logic [value_w-1:0] shown_value;

  // Hex nibble to active-low segments, gfedcba
  function automatic seg_t seg_decode(input logic [3:0] nibble);
    case (nibble)
      4'h0: seg_decode = 7'b1000000;
      4'h1: seg_decode = 7'b1111001;
      4'h2: seg_decode = 7'b0100100;
      4'h3: seg_decode = 7'b0110000;
      4'h4: seg_decode = 7'b0011001;
      4'h5: seg_decode = 7'b0010010;
      4'h6: seg_decode = 7'b0000010;
      4'h7: seg_decode = 7'b1111000;
      4'h8: seg_decode = 7'b0000000;
      4'h9: seg_decode = 7'b0010000;
      4'ha: seg_decode = 7'b0001000;
      4'hb: seg_decode = 7'b0000011;
      4'hc: seg_decode = 7'b1000110;
      4'hd: seg_decode = 7'b0100001;
      4'he: seg_decode = 7'b0000110;
      default: seg_decode = 7'b0001110;
    endcase
  endfunction

  // Display only refreshes on the slow tick
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      shown_value <= '0;
    else if (display_tick)
      shown_value <= {{(value_w - $bits(clock_count_t)){1'b0}}, clock_count};
  end

  always_comb
  begin
    for (int i = 0; i < hex_digits; i++)
      hex[i] = seg_decode(shown_value[4*i +: 4]);
  end

endmodule

// File: logic/sample_player_top.sv
`timescale 1ns/1ns

module sample_player_top #(
  parameter int SAMPLE_DIV  = 50000000,
  parameter int MS_DIV      = 50000,
  parameter int DISPLAY_DIV = 25000000
) (
  input  logic                     CLK_50M,
  input  logic                     rst_n,
  input  player_pkg::key_t         key,
  input  player_pkg::flash_rsp_t   flash_rsp,
  output player_pkg::flash_req_t   flash_req,
  output player_pkg::sample_t      sample,
  output logic                     sample_strobe,
  output player_pkg::clock_count_t clock_count,
  output player_pkg::hex_bus_t     hex
);

  logic sample_tick;
  logic ms_tick;
  logic display_tick;
  logic up_event;
  logic down_event;
  logic reset_event;

  // ========================================
  // Tick generators
  // ========================================

  rate_tick_gen #(.DIVIDE(SAMPLE_DIV)) sample_tick_inst (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .tick    (sample_tick)
  );

  rate_tick_gen #(.DIVIDE(MS_DIV)) ms_tick_inst (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .tick    (ms_tick)
  );

  rate_tick_gen #(.DIVIDE(DISPLAY_DIV)) display_tick_inst (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .tick    (display_tick)
  );

  // ========================================
  // Playback and speed path
  // ========================================

  flash_sample_reader flash_sample_reader_inst (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .sample_tick   (sample_tick),
    .flash_rsp     (flash_rsp),
    .flash_req     (flash_req),
    .sample        (sample),
    .sample_strobe (sample_strobe)
  );

  button_event_gen button_event_gen_inst (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .ms_tick     (ms_tick),
    .key         (key),
    .up_event    (up_event),
    .down_event  (down_event),
    .reset_event (reset_event)
  );

  speed_control speed_control_inst (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .up_event    (up_event),
    .down_event  (down_event),
    .reset_event (reset_event),
    .clock_count (clock_count)
  );

  hex_display hex_display_inst (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .display_tick (display_tick),
    .clock_count  (clock_count),
    .hex          (hex)
  );

endmodule

// File: testbench/tb_sample_player.sv
`timescale 1ns/1ns

module tb_sample_player;

  import player_pkg::*;

  localparam int sample_div = 8;
  localparam int ms_div = 2;
  localparam int display_div = 16;
  localparam int window_limit = ms_div * event_window_ticks + 20;
  localparam int read_limit = 200;
  localparam int hold_cycles = 250;
  localparam int watchdog_cycles = read_limit + 6 * window_limit + display_div
                                   + 2 * hold_cycles + 200;

  logic         CLK_50M = 1'b0;
  logic         rst_n;
  key_t         key;
  flash_rsp_t   flash_rsp = '0;
  flash_req_t   flash_req;
  sample_t      sample;
  logic         sample_strobe;
  clock_count_t clock_count;
  hex_bus_t     hex;

  logic [31:0]  lfsr = 32'h4f29_f30d;
  logic [1:0]   delay = '0;
  int           captures = 0;
  logic         read_last = 1'b0;
  int           errors = 0;
  int           failed_tests = 0;
  int           errors_at_start = 0;
  clock_count_t target;

  sample_player_top #(
    .SAMPLE_DIV  (sample_div),
    .MS_DIV      (ms_div),
    .DISPLAY_DIV (display_div)
  ) sample_player_top_inst (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .key           (key),
    .flash_rsp     (flash_rsp),
    .flash_req     (flash_req),
    .sample        (sample),
    .sample_strobe (sample_strobe),
    .clock_count   (clock_count),
    .hex           (hex)
  );

  always #10 CLK_50M = ~CLK_50M;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Word n holds ~n in the upper half and n in the lower half
  function automatic sample_t expected_sample(input int n);
    sample_t a;
    a = sample_t'(n);
    return n[0] ? ~a : a;
  endfunction

  // Lit segments gfedcba, inverted for the board
  function automatic hex_bus_t expected_hex(input clock_count_t value);
    logic [6:0]  lit [16];
    logic [23:0] wide;
    hex_bus_t    h;
    lit = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
            7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};
    wide = {8'h00, value};
    for (int i = 0; i < hex_digits; i++)
      h[i] = ~lit[wide[4*i +: 4]];
    return h;
  endfunction

  task automatic note_failure(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic wait_count(input clock_count_t value, input int limit);
    for (int i = 0; i < limit && clock_count != value; i++)
      @(negedge CLK_50M);
  endtask

  task automatic end_test(input string name);
    if (errors == errors_at_start)
      $display("test %-12s ok", name);
    else
    begin
      $display("test %-12s FAILED, %0d errors", name, errors - errors_at_start);
      failed_tests++;
    end
    errors_at_start = errors;
  endtask

  // ========================================
  // Flash responder and checkers
  // ========================================

  // Answers each read after 0 to 3 cycles
  always
  begin
    @(negedge CLK_50M);
    if (rst_n && flash_req.read)
    begin
      for (int b = 0; b < 2; b++)
      begin
        lfsr = lfsr_step(lfsr);
        delay = {delay[0], lfsr[0]};
      end
      repeat (delay) @(negedge CLK_50M);
      flash_rsp.readdata = {~flash_req.address[15:0], flash_req.address[15:0]};
      flash_rsp.readdatavalid = 1'b1;
      @(negedge CLK_50M);
      flash_rsp.readdatavalid = 1'b0;
    end
  end

  always @(negedge CLK_50M)
  begin
    if (rst_n)
    begin
      if (flash_req.read && !read_last)
        assert (flash_req.address == flash_addr_t'(captures))
        else note_failure($sformatf("read address %0d, expected %0d",
                                    flash_req.address, captures));
      if (sample_strobe)
      begin
        assert (sample == expected_sample(captures))
        else note_failure($sformatf("sample %h, expected %h for address %0d",
                                    sample, expected_sample(captures), captures));
        captures++;
      end
    end
    read_last = flash_req.read;
  end

  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_req.read && !flash_rsp.readdatavalid |=> flash_req.read && $stable(flash_req.address))
  else note_failure("read dropped or address moved before readdatavalid");

  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_req.read && flash_rsp.readdatavalid |=> sample_strobe && !flash_req.read)
  else note_failure("no strobe or read still high after capture");

  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    sample_strobe |=> !sample_strobe)
  else note_failure("sample_strobe high for more than one cycle");

  // Count moves by one step or returns to the default
  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    !$stable(clock_count) |-> (clock_count == default_clock_count)
      || (clock_count == $past(clock_count) + clock_count_t'(speed_step))
      || (clock_count == $past(clock_count) - clock_count_t'(speed_step)))
  else note_failure($sformatf("clock_count jumped to %0d", clock_count));

  // ========================================
  // Test sequence
  // ========================================

  initial
  begin
    rst_n = 1'b0;
    key = '1;
    repeat (2) @(posedge CLK_50M);
    @(negedge CLK_50M);
    rst_n = 1'b1;

    @(negedge CLK_50M);
    assert (!flash_req.read && !sample_strobe) else note_failure("read or strobe high after reset");
    assert (clock_count == default_clock_count)
    else note_failure($sformatf("clock_count %0d after reset", clock_count));
    assert (hex == expected_hex('0)) else note_failure("digits not all zero after reset");
    end_test("reset");

    for (int i = 0; i < read_limit && captures < 8; i++)
      @(negedge CLK_50M);
    assert (captures >= 8) else note_failure($sformatf("only %0d samples captured", captures));
    end_test("flash reads");

    key.speed_up = 1'b0;
    for (int k = 1; k <= 3; k++)
    begin
      target = default_clock_count + clock_count_t'(100 * k);
      wait_count(target, window_limit);
      assert (clock_count == target)
      else note_failure($sformatf("clock_count %0d, expected %0d", clock_count, target));
    end
    key.speed_up = 1'b1;
    for (int i = 0; i < display_div + 4 && hex != expected_hex(16'd12799); i++)
      @(negedge CLK_50M);
    assert (hex == expected_hex(16'd12799)) else note_failure("digits do not show 0031ff");
    end_test("speed up");

    key.speed_down = 1'b0;
    for (int k = 1; k <= 2; k++)
    begin
      target = 16'd12799 - clock_count_t'(100 * k);
      wait_count(target, window_limit);
      assert (clock_count == target)
      else note_failure($sformatf("clock_count %0d, expected %0d", clock_count, target));
    end
    // Both keys held cancel each other
    key.speed_up = 1'b0;
    repeat (hold_cycles)
    begin
      @(negedge CLK_50M);
      assert (clock_count == 16'd12599)
      else note_failure($sformatf("clock_count %0d with both keys held", clock_count));
    end
    end_test("slow down");

    key.speed_down = 1'b1;
    key.speed_reset = 1'b0;
    wait_count(default_clock_count, 10);
    repeat (hold_cycles)
    begin
      assert (clock_count == default_clock_count)
      else note_failure($sformatf("clock_count %0d with reset key held", clock_count));
      @(negedge CLK_50M);
    end
    key = '1;
    end_test("speed reset");

    $display("summary: 5 tests run, %0d with errors, %0d check failures", failed_tests, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  initial
  begin
    #(watchdog_cycles * 20);
    $display("The run timed out after %0d cycles before all tests finished", watchdog_cycles);
    $display("tests failed");
    $finish;
  end

endmodule

// File: all.f
logic/player_pkg.sv
logic/rate_tick_gen.sv
logic/flash_sample_reader.sv
logic/button_event_gen.sv
logic/speed_control.sv
logic/hex_display.sv
logic/sample_player_top.sv
testbench/tb_sample_player.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_sample_player -Mdir obj_dir

./obj_dir/Vtb_sample_player 2>&1 | tee sim.log

if grep -q "tests failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi

echo "Simulation finished without a reported failure"
